// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // physical register file geometry
    localparam int NUM_PREGS = 64;
    localparam int PREG_W    = $clog2(NUM_PREGS);

    // reorder buffer geometry, only the index travels through this block
    localparam int ROB_SIZE = 32;
    localparam int ROB_W    = $clog2(ROB_SIZE);

    // rv32i major opcodes handled by the memory pipe
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // access size held in funct3[1:0], funct3[2] marks an unsigned load
    localparam logic [1:0] size_byte = 2'b00;
    localparam logic [1:0] size_half = 2'b01;
    localparam logic [1:0] size_word = 2'b10;

    // one load/store queue slot
    typedef struct packed {
        logic [6:0]        opcode;
        logic [2:0]        funct3;
        logic              amo;       // ordered like a store, returns data like a load
        logic [PREG_W-1:0] pr1;       // base address register
        logic [PREG_W-1:0] pr2;       // store data register, 0 when unused
        logic [PREG_W-1:0] phys_rd;   // load destination
        logic [ROB_W-1:0]  rob_index;
        logic [11:0]       imm;       // signed byte offset
    } lsq_entry_t;

endpackage

`default_nettype wire

// ==== rtl/lsq_issue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lsq_issue_if
    import lsu_pkg::*;
();

    logic       req;    // queue has a stable head entry on offer
    logic       ack;    // address stage has latched the entry
    lsq_entry_t entry;

    // four-phase exchange: req up, ack up, req down with the pop, ack down
    modport issuer (
        output req,
        output entry,
        input  ack
    );

    modport receiver (
        input  req,
        input  entry,
        output ack
    );

endinterface

`default_nettype wire

// ==== rtl/phys_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              clear_valid,
    input  wire logic [PREG_W-1:0] clear_preg,
    input  wire logic              wb_valid,
    input  wire logic [PREG_W-1:0] wb_preg,
    input  wire logic [31:0]       wb_data,
    input  wire logic              ld_wb_valid,
    input  wire logic [PREG_W-1:0] ld_wb_preg,
    input  wire logic [31:0]       ld_wb_data,
    input  wire logic [PREG_W-1:0] rd1_preg,
    input  wire logic [PREG_W-1:0] rd2_preg,
    output logic      [31:0]       rd1_data,
    output logic      [31:0]       rd2_data,
    input  wire logic [PREG_W-1:0] q1_preg,
    input  wire logic [PREG_W-1:0] q2_preg,
    output logic                   q1_ready,
    output logic                   q2_ready
);

    logic [31:0]          values [NUM_PREGS];
    logic [NUM_PREGS-1:0] ready;

    // register 0 is never written or cleared, so it stays zero and ready after reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ready <= '1;
            for (int i = 0; i < NUM_PREGS; i++)
            begin
                values[i] <= '0;
            end
        end
        else
        begin
            if (wb_valid && wb_preg != '0)
            begin
                values[wb_preg] <= wb_data;
                ready[wb_preg]  <= 1'b1;
            end
            if (ld_wb_valid && ld_wb_preg != '0)
            begin
                values[ld_wb_preg] <= ld_wb_data;
                ready[ld_wb_preg]  <= 1'b1;
            end
            if (clear_valid && clear_preg != '0)
            begin
                ready[clear_preg] <= 1'b0;  // a new dispatch owns the register from here on
            end
        end
    end

    assign rd1_data = values[rd1_preg];
    assign rd2_data = values[rd2_preg];
    assign q1_ready = ready[q1_preg];
    assign q2_ready = ready[q2_preg];

    // the alu path and the load path never retire into the same register together
    a_single_writer: assert property (@(posedge clk) disable iff (rst)
        !(wb_valid && ld_wb_valid && wb_preg == ld_wb_preg && wb_preg != '0))
        else $error("phys_reg_file: both write ports target preg %0d", wb_preg);

endmodule

`default_nettype wire

// ==== rtl/load_store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_queue
    import lsu_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8   // power of two so the pointers wrap by themselves
)
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush,
    input  wire logic              disp_valid,
    input  wire lsq_entry_t        disp_entry,
    output logic                   disp_ready,
    input  wire logic [ROB_W-1:0]  rob_head,
    output logic      [PREG_W-1:0] q1_preg,
    output logic      [PREG_W-1:0] q2_preg,
    input  wire logic              q1_ready,
    input  wire logic              q2_ready,
    lsq_issue_if.issuer            issue
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    lsq_entry_t       slots [QUEUE_DEPTH];
    logic [PTR_W:0]   rd_ptr;       // msb is the wrap bit
    logic [PTR_W:0]   wr_ptr;
    logic             open;         // dispatch opens the cycle after reset is released
    logic             empty;
    logic             full;
    logic             push;
    logic             pop;
    logic             ordered;
    logic             eligible;
    lsq_entry_t       head;

    assign head  = slots[rd_ptr[PTR_W-1:0]];
    assign empty = rd_ptr == wr_ptr;
    assign full  = rd_ptr[PTR_W-1:0] == wr_ptr[PTR_W-1:0] && rd_ptr[PTR_W] != wr_ptr[PTR_W];

    assign disp_ready = open && !full;
    assign push       = disp_valid && disp_ready;
    assign pop        = issue.req && issue.ack;

    // readiness query always looks at the oldest entry
    assign q1_preg = head.pr1;
    assign q2_preg = head.pr2;

    // stores and amos may only touch memory once they are the oldest in the rob
    assign ordered  = head.opcode == op_store || head.amo;
    assign eligible = !empty && q1_ready && q2_ready && (!ordered || rob_head == head.rob_index);

    assign issue.entry = head;  // rd_ptr cannot move while req is up, so this stays stable

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            slots[wr_ptr[PTR_W-1:0]] <= disp_entry;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            issue.req <= 1'b0;
            open      <= !rst;
        end
        else
        begin
            open <= 1'b1;
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr    <= rd_ptr + 1'b1;
                issue.req <= 1'b0;
            end
            else if (!issue.req && !issue.ack && eligible)
            begin
                issue.req <= 1'b1;  // wait for the previous ack to fall before offering again
            end
        end
    end

    // occupancy never exceeds the slot count
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (wr_ptr - rd_ptr) <= (PTR_W + 1)'(QUEUE_DEPTH))
        else $error("load_store_queue: write pointer overran read pointer");

    // the address stage may latch the entry any cycle while req is up
    a_entry_stable: assert property (@(posedge clk) disable iff (rst)
        issue.req && !pop && !flush |=> $stable(issue.entry))
        else $error("load_store_queue: head entry changed under req");

endmodule

`default_nettype wire

// ==== rtl/addr_gen_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_gen_unit
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush,
    lsq_issue_if.receiver          issue,
    output logic      [PREG_W-1:0] rd1_preg,
    output logic      [PREG_W-1:0] rd2_preg,
    input  wire logic [31:0]       rd1_data,
    input  wire logic [31:0]       rd2_data,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic      [31:0]       mem_addr,
    output logic      [31:0]       mem_wdata,
    output logic      [3:0]        mem_wmask,
    input  wire logic              mem_ack,
    input  wire logic [31:0]       mem_rdata,
    output logic                   ld_wb_valid,
    output logic      [PREG_W-1:0] ld_wb_preg,
    output logic      [31:0]       ld_wb_data,
    output logic                   done_valid,
    output logic      [ROB_W-1:0]  done_rob_index,
    output logic      [31:0]       done_data
);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_acked = 2'd1;
    localparam logic [1:0] st_mem   = 2'd2;
    localparam logic [1:0] st_drop  = 2'd3;

    logic [1:0]  state;
    logic        killed;        // flushed while in flight, finish the bus cycle quietly
    logic        take;
    logic [2:0]  funct3;
    logic [31:0] eff_addr;
    logic [31:0] wdata;
    logic [3:0]  wmask;
    logic [31:0] lane;
    logic [31:0] ld_value;

    assign rd1_preg = issue.entry.pr1;
    assign rd2_preg = issue.entry.pr2;
    assign take     = state == st_idle && issue.req && !issue.ack;
    assign eff_addr = rd1_data + {{20{issue.entry.imm[11]}}, issue.entry.imm};

    always_comb
    begin
        case (issue.entry.funct3[1:0])
            size_byte:
            begin
                wdata = {4{rd2_data[7:0]}};
                wmask = 4'b0001 << eff_addr[1:0];
            end
            size_half:
            begin
                wdata = {2{rd2_data[15:0]}};
                wmask = 4'b0011 << eff_addr[1:0];
            end
            default:
            begin
                wdata = rd2_data;
                wmask = 4'b1111;
            end
        endcase
    end

    // move the addressed lane down to bit 0, then extend by size and signedness
    assign lane = mem_rdata >> {mem_addr[1:0], 3'b000};

    always_comb
    begin
        case (funct3[1:0])
            size_byte: ld_value = funct3[2] ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
            size_half: ld_value = funct3[2] ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
            default:   ld_value = lane;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            funct3         <= issue.entry.funct3;
            mem_addr       <= eff_addr;
            mem_wdata      <= wdata;
            mem_wmask      <= wmask;
            ld_wb_preg     <= issue.entry.phys_rd;
            done_rob_index <= issue.entry.rob_index;
        end
        if (state == st_mem && mem_ack)
        begin
            ld_wb_data <= ld_value;
            done_data  <= mem_we ? 32'b0 : ld_value;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= st_idle;
            issue.ack   <= 1'b0;
            mem_req     <= 1'b0;
            mem_we      <= 1'b0;
            killed      <= 1'b0;
            ld_wb_valid <= 1'b0;
            done_valid  <= 1'b0;
        end
        else
        begin
            ld_wb_valid <= 1'b0;
            done_valid  <= 1'b0;
            if (issue.ack && !issue.req)
            begin
                issue.ack <= 1'b0;
            end
            case (state)
                st_idle:
                begin
                    if (take)
                    begin
                        issue.ack <= 1'b1;
                        mem_we    <= issue.entry.opcode == op_store && !issue.entry.amo;
                        killed    <= flush;
                        state     <= st_acked;
                    end
                end
                st_acked:
                begin
                    if (killed || flush)
                    begin
                        killed <= 1'b0;  // nothing reached the bus yet, just drop it
                        state  <= st_idle;
                    end
                    else
                    begin
                        mem_req <= 1'b1;
                        state   <= st_mem;
                    end
                end
                st_mem:
                begin
                    if (flush)
                    begin
                        killed <= 1'b1;
                    end
                    if (mem_ack)
                    begin
                        mem_req     <= 1'b0;
                        ld_wb_valid <= !mem_we && !killed && !flush;
                        done_valid  <= !killed && !flush;
                        state       <= st_drop;
                    end
                end
                default:
                begin
                    if (!mem_ack)
                    begin
                        killed <= 1'b0;
                        state  <= st_idle;
                    end
                end
            endcase
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
        else $error("addr_gen_unit: mem_req dropped before mem_ack");

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> (funct3[1:0] == size_byte)
                 || (funct3[1:0] == size_half && !mem_addr[0])
                 || (mem_addr[1:0] == 2'b00))
        else $error("addr_gen_unit: misaligned access at %h", mem_addr);

endmodule

`default_nettype wire

// ==== rtl/mem_issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_issue_top
    import lsu_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
)
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush,
    input  wire logic [ROB_W-1:0]  rob_head,
    input  wire logic              disp_valid,
    input  wire logic [6:0]        disp_opcode,
    input  wire logic [2:0]        disp_funct3,
    input  wire logic              disp_amo,
    input  wire logic [PREG_W-1:0] disp_pr1,
    input  wire logic [PREG_W-1:0] disp_pr2,
    input  wire logic [PREG_W-1:0] disp_phys_rd,
    input  wire logic [ROB_W-1:0]  disp_rob_index,
    input  wire logic [11:0]       disp_imm,
    output logic                   disp_ready,
    input  wire logic              wb_valid,
    input  wire logic [PREG_W-1:0] wb_preg,
    input  wire logic [31:0]       wb_data,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic      [31:0]       mem_addr,
    output logic      [31:0]       mem_wdata,
    output logic      [3:0]        mem_wmask,
    input  wire logic              mem_ack,
    input  wire logic [31:0]       mem_rdata,
    output logic                   done_valid,
    output logic      [ROB_W-1:0]  done_rob_index,
    output logic      [31:0]       done_data
);

    lsq_entry_t        disp_entry;
    logic              clear_valid;
    logic [PREG_W-1:0] q1_preg;
    logic [PREG_W-1:0] q2_preg;
    logic              q1_ready;
    logic              q2_ready;
    logic [PREG_W-1:0] rd1_preg;
    logic [PREG_W-1:0] rd2_preg;
    logic [31:0]       rd1_data;
    logic [31:0]       rd2_data;
    logic              ld_wb_valid;
    logic [PREG_W-1:0] ld_wb_preg;
    logic [31:0]       ld_wb_data;

    assign disp_entry = '{opcode: disp_opcode, funct3: disp_funct3, amo: disp_amo,
                          pr1: disp_pr1, pr2: disp_pr2, phys_rd: disp_phys_rd,
                          rob_index: disp_rob_index, imm: disp_imm};

    // a load or amo destination goes busy the moment it is accepted
    assign clear_valid = disp_valid && disp_ready && (disp_opcode == op_load || disp_amo);

    lsq_issue_if i_issue_if ();

    phys_reg_file i_prf (
        .clk, .rst,
        .clear_valid, .clear_preg(disp_phys_rd),
        .wb_valid, .wb_preg, .wb_data,
        .ld_wb_valid, .ld_wb_preg, .ld_wb_data,
        .rd1_preg, .rd2_preg, .rd1_data, .rd2_data,
        .q1_preg, .q2_preg, .q1_ready, .q2_ready
    );

    load_store_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_lsq (
        .clk, .rst, .flush,
        .disp_valid, .disp_entry, .disp_ready,
        .rob_head,
        .q1_preg, .q2_preg, .q1_ready, .q2_ready,
        .issue(i_issue_if.issuer)
    );

    addr_gen_unit i_agu (
        .clk, .rst, .flush,
        .issue(i_issue_if.receiver),
        .rd1_preg, .rd2_preg, .rd1_data, .rd2_data,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_wmask, .mem_ack, .mem_rdata,
        .ld_wb_valid, .ld_wb_preg, .ld_wb_data,
        .done_valid, .done_rob_index, .done_data
    );

endmodule

`default_nettype wire

// ==== testbench/tb_mem_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_issue;

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    logic [4:0]  rob_head;
    logic        disp_valid;
    logic [6:0]  disp_opcode;
    logic [2:0]  disp_funct3;
    logic        disp_amo;
    logic [5:0]  disp_pr1;
    logic [5:0]  disp_pr2;
    logic [5:0]  disp_phys_rd;
    logic [4:0]  disp_rob_index;
    logic [11:0] disp_imm;
    logic        disp_ready;
    logic        wb_valid;
    logic [5:0]  wb_preg;
    logic [31:0] wb_data;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wmask;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        done_valid;
    logic [4:0]  done_rob_index;
    logic [31:0] done_data;

    logic [31:0] mem_words [256];
    logic [73:0] exp_mem [$];      // we, addr, wdata, wmask, rob
    logic [36:0] exp_done [$];     // rob, data
    string       lines [$];
    string       test_name = "";
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          limit_cycles = 0;
    logic [31:0] lfsr = 32'h5ef2_0b64;
    logic        req_seen = 1'b0;
    logic        counting = 1'b0;
    int          wait_cnt = 0;

    // smaller queue so that back-pressure needs only a few dispatches
    mem_issue_top #(.QUEUE_DEPTH(4)) i_mem_issue_top (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // true while a completion for this rob index is still outstanding
    function automatic logic done_pending(input logic [4:0] rob);
        foreach (exp_done[i])
        begin
            if (exp_done[i][36:32] == rob)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED %s got %h expected %h", sig, got, exp);
        errors++;
    endtask

    task automatic event_error(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    // memory answers after 0 to 3 cycles, two lfsr bits per request
    always @(posedge clk)
    begin
        #1;
        if (rst)
        begin
            mem_ack = 1'b0;
            counting = 1'b0;
        end
        else if (mem_ack)
        begin
            if (!mem_req)
            begin
                mem_ack = 1'b0;
            end
        end
        else if (mem_req)
        begin
            if (!counting)
            begin
                lfsr = lfsr_step(lfsr);
                wait_cnt = lfsr[0];
                lfsr = lfsr_step(lfsr);
                wait_cnt = wait_cnt * 2 + lfsr[0];
                counting = 1'b1;
            end
            if (wait_cnt == 0)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (mem_we && mem_wmask[b])
                    begin
                        mem_words[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
                    end
                end
                mem_rdata = mem_words[mem_addr[9:2]];
                mem_ack = 1'b1;
                counting = 1'b0;
            end
            else
            begin
                wait_cnt--;
            end
        end
    end

    // outputs are compared mid-cycle where they are stable
    always @(negedge clk)
    begin
        logic [73:0] m;
        logic [36:0] d;
        if (!rst && mem_req && !req_seen)
        begin
            if (exp_mem.size() == 0)
            begin
                event_error($sformatf("memory request at %h with no operation expected", mem_addr));
            end
            else
            begin
                m = exp_mem.pop_front();
                if (mem_we !== m[73])
                    value_error("mem_we", 32'(mem_we), 32'(m[73]));
                if (mem_addr !== m[72:41])
                    value_error("mem_addr", mem_addr, m[72:41]);
                if (m[73] && mem_wdata !== m[40:9])
                    value_error("mem_wdata", mem_wdata, m[40:9]);
                if (m[73] && mem_wmask !== m[8:5])
                    value_error("mem_wmask", 32'(mem_wmask), 32'(m[8:5]));
                if (m[73] && rob_head !== m[4:0])
                    value_error("rob_head at store issue", 32'(rob_head), 32'(m[4:0]));
            end
        end
        if (!rst && done_valid)
        begin
            if (exp_done.size() == 0)
            begin
                event_error($sformatf("done pulse for rob %h with none expected", done_rob_index));
            end
            else
            begin
                d = exp_done.pop_front();
                if (done_rob_index !== d[36:32])
                    value_error("done_rob_index", 32'(done_rob_index), 32'(d[36:32]));
                if (done_data !== d[31:0])
                    value_error("done_data", done_data, d[31:0]);
            end
        end
        req_seen = mem_req;
    end

    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic dispatch(input logic [31:0] f [8]);
        int n;
        n = 0;
        disp_valid     = 1'b1;
        disp_opcode    = f[0][6:0];
        disp_funct3    = f[1][2:0];
        disp_amo       = f[2][0];
        disp_pr1       = f[3][5:0];
        disp_pr2       = f[4][5:0];
        disp_phys_rd   = f[5][5:0];
        disp_rob_index = f[6][4:0];
        disp_imm       = f[7][11:0];
        @(negedge clk);
        while (!disp_ready && n < 200)
        begin
            n++;
            @(negedge clk);
        end
        if (!disp_ready)
            event_error($sformatf("dispatch of rob %h never accepted", disp_rob_index));
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    task automatic close_test();
        int n;
        n = 0;
        while ((exp_mem.size() != 0 || exp_done.size() != 0) && n < 300)
        begin
            n++;
            @(posedge clk);
        end
        if (exp_mem.size() != 0 || exp_done.size() != 0)
        begin
            event_error($sformatf("%0d memory and %0d done events never arrived",
                                  exp_mem.size(), exp_done.size()));
            exp_mem.delete();
            exp_done.delete();
        end
        repeat (8) @(posedge clk);  // catch stray events after the last expected one
        #1;
        tests_run++;
        if (errors == test_errors)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic run_record(input string line);
        string       tag;
        string       name;
        logic [31:0] f [8];
        int          n;
        n = 0;
        if (line.len() < 2 || line.getc(0) == "#")
            return;
        void'($sscanf(line, "%s %h %h %h %h %h %h %h %h",
                      tag, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]));
        case (tag)
            "T":
            begin
                if (test_name != "")
                    close_test();
                void'($sscanf(line, "%s %s", tag, name));
                test_name = name;
                test_errors = errors;
            end
            "D": dispatch(f);
            "W":
            begin
                wb_valid = 1'b1;
                wb_preg  = f[0][5:0];
                wb_data  = f[1];
                @(posedge clk);
                #1;
                wb_valid = 1'b0;
            end
            "H":
            begin
                // the rob head moves on only once the operation it points at has completed
                while (done_pending(rob_head) && n < 300)
                begin
                    n++;
                    @(posedge clk);
                    #1;
                end
                if (done_pending(rob_head))
                    event_error($sformatf("rob %h never completed at the head", rob_head));
                rob_head = f[0][4:0];
            end
            "F":
            begin
                flush = 1'b1;
                @(posedge clk);
                #1;
                flush = 1'b0;
            end
            "Y":
            begin
                repeat (f[0]) @(posedge clk);
                #1;
            end
            "Q":
            begin
                while (!mem_req && n < 100)
                begin
                    n++;
                    @(posedge clk);
                    #1;
                end
                if (!mem_req)
                    event_error("memory request never rose");
            end
            "B":
            begin
                @(negedge clk);
                if (disp_ready !== f[0][0])
                    value_error("disp_ready", 32'(disp_ready), f[0]);
                @(posedge clk);
                #1;
            end
            "M": exp_mem.push_back({f[0][0], f[1], f[2], f[3][3:0], f[4][4:0]});
            "C": exp_done.push_back({f[0][4:0], f[1]});
            default: event_error($sformatf("unknown record '%s'", tag));
        endcase
    endtask

    initial
    begin
        int    fd;
        string line;
        rst = 1'b1;
        flush = 1'b0;
        rob_head = '0;
        disp_valid = 1'b0;
        disp_opcode = '0;
        disp_funct3 = '0;
        disp_amo = 1'b0;
        disp_pr1 = '0;
        disp_pr2 = '0;
        disp_phys_rd = '0;
        disp_rob_index = '0;
        disp_imm = '0;
        wb_valid = 1'b0;
        wb_preg = '0;
        wb_data = '0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < 256; i++)
        begin
            mem_words[i] = {i[7:0] ^ 8'hf0, i[7:0] ^ 8'h0f, i[7:0] ^ 8'hc3, i[7:0] ^ 8'h3c};
        end
        fd = $fopen("testbench/mem_issue_input.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open testbench/mem_issue_input.txt");
            $display("TEST FAILED");
            $finish;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                lines.push_back(line);
            end
            $fclose(fd);
            limit_cycles = 400 + 60 * lines.size();
            repeat (10) @(posedge clk);
            #1;
            rst = 1'b0;
            foreach (lines[i])
            begin
                run_record(lines[i]);
            end
            if (test_name != "")
                close_test();
            $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
            if (errors == 0)
            begin
                $display("TEST PASSED");
            end
            else
            begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/mem_issue_input.txt ====
# D opcode funct3 amo pr1 pr2 rd rob imm | W preg data | H rob | F | Y cycles | Q | B ready
# M we addr wdata wmask rob | C rob data | T name   (all numbers hex)
T operand_gating
M 0 00000104 0 0 01
C 01 b14e827d
M 0 b14e8279 0 0 02
C 02 0000005d
W 05 00000100
D 03 2 0 05 00 06 01 004
D 03 0 0 06 00 07 02 ffc
T store_ordering
M 1 00000041 cdcdcdcd 2 0a
M 1 00000042 abcdabcd c 0b
M 1 00000048 1234abcd f 0c
C 0a 0
C 0b 0
C 0c 0
W 0a 1234abcd
D 23 0 0 00 0a 00 0a 041
Y 8
H 0a
D 23 1 0 00 0a 00 0b 042
H 0b
D 23 2 0 00 0a 00 0c 048
H 0c
T load_extension
M 0 00000043 0 0 0d
M 0 00000042 0 0 0e
M 0 00000040 0 0 0f
M 0 00000042 0 0 10
M 0 00000048 0 0 11
M 1 00000050 ffffffab f 12
M 0 00000050 0 0 13
C 0d ffffffab
C 0e 000000cd
C 0f ffffcd2c
C 10 0000abcd
C 11 1234abcd
C 12 0
C 13 ffffffab
H 12
D 03 0 0 00 00 10 0d 043
D 03 4 0 00 00 11 0e 042
D 03 1 0 00 00 12 0f 040
D 03 5 0 00 00 13 10 042
D 03 2 0 00 00 14 11 048
D 23 2 0 00 10 00 12 050
D 03 2 0 00 00 15 13 050
T completion_order
M 0 00000104 0 0 14
M 1 00000060 1234abcd f 15
M 0 00000060 0 0 16
C 14 b14e827d
C 15 0
C 16 1234abcd
H 15
D 03 2 0 00 00 16 14 104
D 23 2 0 00 14 00 15 060
D 03 2 0 00 00 17 16 060
T back_pressure
M 1 00000070 00000000 f 18
M 0 00000070 0 0 19
M 0 00000070 0 0 1a
M 0 00000070 0 0 1b
C 18 0
C 19 0
C 1a 0
C 1b 0
H 00
D 23 2 0 00 00 00 18 070
D 03 2 0 00 00 20 19 070
D 03 2 0 00 00 21 1a 070
D 03 2 0 00 00 22 1b 070
Y 4
B 0
H 18
Y 6
B 1
T flush
H 00
M 0 00000080 0 0 01
D 03 2 0 00 00 30 01 080
D 23 2 0 00 00 00 02 090
D 03 2 0 30 00 32 03 000
Q
F
Y 8
M 0 00000204 0 0 04
C 04 718e42bd
D 03 2 0 30 00 31 04 004
Y 6
W 30 00000200

// ==== all.f ====
rtl/lsu_pkg.sv
rtl/lsq_issue_if.sv
rtl/phys_reg_file.sv
rtl/load_store_queue.sv
rtl/addr_gen_unit.sv
rtl/mem_issue_top.sv
testbench/tb_mem_issue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory-issue testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_mem_issue -f all.f

out=$(./obj_dir/Vtb_mem_issue 2>&1) || true
echo "$out"

# the run passes only if the testbench printed its pass line
grep -qx "TEST PASSED" <<< "$out"
